// File: Makefile
VERILATOR  ?= verilator
TOP        ?= goal_view_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --timing --assert
SIMFLAGS   ?= +verilator+error+limit+1000

FAIL_MSG := Simulation FAILED
PASS_MSG := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
src/vga_pkg.sv
src/vga_timing.sv
src/draw_background.sv
src/draw_ball.sv
src/goal_view_top.sv
test/goal_view_assertions.sv
test/goal_view_tb.sv

// File: src/draw_background.sv
`timescale 1ns/1ns

module draw_background (
  input  logic             clk,
  input  logic             rst,
  input  vga_pkg::timing_t tim,
  output vga_pkg::pixel_t  pix
);

  logic [vga_pkg::rgb_w-1:0] rgb_nxt;

  // offsets into the net grid
  logic [vga_pkg::cnt_w-1:0] net_dx;
  logic [vga_pkg::cnt_w-1:0] net_dy;

  logic blank;
  logic in_left_post;
  logic in_right_post;
  logic in_crossbar;
  logic in_frame;
  logic in_opening;
  logic in_net;
  logic on_goal_line;
  logic on_six_yard;
  logic on_spot;
  logic in_grass;

  assign blank = tim.hblnk || tim.vblnk;

  // posts run from the crossbar top down to the goal line
  assign in_left_post  = (tim.hcount >= vga_pkg::post_left) &&
                         (tim.hcount <  vga_pkg::net_left) &&
                         (tim.vcount >= vga_pkg::crossbar_top) &&
                         (tim.vcount <  vga_pkg::goal_line_bottom);

  // right post band ends on its outer column
  assign in_right_post = (tim.hcount >  vga_pkg::net_right) &&
                         (tim.hcount <= vga_pkg::post_right) &&
                         (tim.vcount >= vga_pkg::crossbar_top) &&
                         (tim.vcount <  vga_pkg::goal_line_bottom);

  assign in_crossbar   = (tim.hcount >= vga_pkg::post_left) &&
                         (tim.hcount <= vga_pkg::post_right) &&
                         (tim.vcount >= vga_pkg::crossbar_top) &&
                         (tim.vcount <  vga_pkg::net_top);

  assign in_frame = in_left_post || in_right_post || in_crossbar;

  assign in_opening = (tim.hcount >= vga_pkg::net_left) &&
                      (tim.hcount <= vga_pkg::net_right) &&
                      (tim.vcount >= vga_pkg::net_top) &&
                      (tim.vcount <  vga_pkg::goal_line_top);

  assign net_dx = tim.hcount - vga_pkg::post_left;
  assign net_dy = tim.vcount - vga_pkg::crossbar_top;

  // pitch is a power of two, so the modulo is just the low bits
  assign in_net = in_opening &&
                  ((net_dx[vga_pkg::net_shift-1:0] == '0) ||
                   (net_dy[vga_pkg::net_shift-1:0] == '0));

  assign on_goal_line = (tim.vcount >= vga_pkg::goal_line_top) &&
                        (tim.vcount <  vga_pkg::goal_line_bottom);
  assign on_six_yard  = (tim.vcount >= vga_pkg::six_yard_top) &&
                        (tim.vcount <  vga_pkg::six_yard_bottom);

  assign on_spot = (tim.hcount >= vga_pkg::spot_x - vga_pkg::spot_half) &&
                   (tim.hcount <  vga_pkg::spot_x + vga_pkg::spot_half) &&
                   (tim.vcount >= vga_pkg::spot_y - vga_pkg::spot_half) &&
                   (tim.vcount <  vga_pkg::spot_y + vga_pkg::spot_half);

  assign in_grass = (tim.vcount >= vga_pkg::grass_top);

  // colour by priority, frame over net over lines over ground
  always_comb begin
    if (blank) begin
      rgb_nxt = vga_pkg::black;
    end else if (in_frame) begin
      rgb_nxt = vga_pkg::post;
    end else if (in_net) begin
      rgb_nxt = vga_pkg::net;
    end else if (on_goal_line || on_six_yard || on_spot) begin
      rgb_nxt = vga_pkg::line;
    end else if (in_grass) begin
      rgb_nxt = vga_pkg::grass;
    end else begin
      rgb_nxt = vga_pkg::sky;
    end
  end

  // timing passes through unchanged, one cycle late
  always_ff @(posedge clk) begin
    if (rst) begin
      pix <= '0;
    end else begin
      pix.tim <= tim;
      pix.rgb <= rgb_nxt;
    end
  end

endmodule

// File: src/draw_ball.sv
`timescale 1ns/1ns

module draw_ball (
  input  logic                      clk,
  input  logic                      rst,
  input  vga_pkg::pixel_t           pix_in,
  input  logic [vga_pkg::cnt_w-1:0] ball_x,
  input  logic [vga_pkg::cnt_w-1:0] ball_y,
  output vga_pkg::pixel_t           pix
);

  // corner held steady for a whole frame
  logic [vga_pkg::cnt_w-1:0] ball_x_q;
  logic [vga_pkg::cnt_w-1:0] ball_y_q;

  logic [vga_pkg::cnt_w-1:0] dx;
  logic [vga_pkg::cnt_w-1:0] dy;
  logic                      frame_start;
  logic                      in_ball;
  logic                      blank;

  // first pixel of the first blanking line
  assign frame_start = (pix_in.tim.hcount == '0) &&
                       (pix_in.tim.vcount == vga_pkg::ver_pixels);

  always_ff @(posedge clk) begin
    if (rst) begin
      ball_x_q <= '0;
      ball_y_q <= '0;
    end else if (frame_start) begin
      ball_x_q <= ball_x;
      ball_y_q <= ball_y;
    end
  end

  // offsets from the corner, compared without overflow
  assign dx = pix_in.tim.hcount - ball_x_q;
  assign dy = pix_in.tim.vcount - ball_y_q;

  assign blank = pix_in.tim.hblnk || pix_in.tim.vblnk;

  assign in_ball = !blank &&
                   (pix_in.tim.hcount >= ball_x_q) && (dx < vga_pkg::ball_size) &&
                   (pix_in.tim.vcount >= ball_y_q) && (dy < vga_pkg::ball_size);

  always_ff @(posedge clk) begin
    if (rst) begin
      pix <= '0;
    end else begin
      pix.tim <= pix_in.tim;
      if (in_ball) begin
        pix.rgb <= vga_pkg::ball;
      end else begin
        pix.rgb <= pix_in.rgb;
      end
    end
  end

endmodule

// File: src/goal_view_top.sv
`timescale 1ns/1ns

module goal_view_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [vga_pkg::cnt_w-1:0] ball_x,
  input  logic [vga_pkg::cnt_w-1:0] ball_y,
  output vga_pkg::pixel_t           vga
);

  // counts from the generator
  vga_pkg::timing_t tim;

  // scene without the ball
  vga_pkg::pixel_t bg_pix;

  vga_timing u_vga_timing (
    .clk (clk),
    .rst (rst),
    .tim (tim)
  );

  draw_background u_draw_background (
    .clk (clk),
    .rst (rst),
    .tim (tim),
    .pix (bg_pix)
  );

  // ball goes on top, two cycles after the counts
  draw_ball u_draw_ball (
    .clk    (clk),
    .rst    (rst),
    .pix_in (bg_pix),
    .ball_x (ball_x),
    .ball_y (ball_y),
    .pix    (vga)
  );

endmodule

// File: src/vga_pkg.sv
package vga_pkg;

  // counter and colour widths
  localparam int cnt_w = 11;
  localparam int rgb_w = 12;

  // 800x600 at 40 MHz pixel clock, 1056x628 total
  localparam logic [cnt_w-1:0] hor_pixels  = 11'd800;
  localparam logic [cnt_w-1:0] hor_total   = 11'd1056;
  localparam logic [cnt_w-1:0] hsync_start = 11'd840;
  localparam logic [cnt_w-1:0] hsync_end   = 11'd968;

  localparam logic [cnt_w-1:0] ver_pixels  = 11'd600;
  localparam logic [cnt_w-1:0] ver_total   = 11'd628;
  localparam logic [cnt_w-1:0] vsync_start = 11'd601;
  localparam logic [cnt_w-1:0] vsync_end   = 11'd605;

  // scene geometry, goalkeeper's view
  localparam logic [cnt_w-1:0] grass_top = 11'd300;

  // outer columns of the two posts
  localparam logic [cnt_w-1:0] post_left    = 11'd200;
  localparam logic [cnt_w-1:0] post_right   = 11'd600;
  localparam logic [cnt_w-1:0] post_width   = 11'd12;
  localparam logic [cnt_w-1:0] crossbar_top = 11'd120;

  localparam logic [cnt_w-1:0] goal_line_top    = 11'd290;
  localparam logic [cnt_w-1:0] goal_line_bottom = 11'd296;
  localparam logic [cnt_w-1:0] six_yard_top     = 11'd400;
  localparam logic [cnt_w-1:0] six_yard_bottom  = 11'd403;

  // penalty spot is a square around its centre
  localparam logic [cnt_w-1:0] spot_x    = 11'd400;
  localparam logic [cnt_w-1:0] spot_y    = 11'd450;
  localparam logic [cnt_w-1:0] spot_half = 11'd8;

  // net grid, pitch must stay a power of two
  localparam logic [cnt_w-1:0] net_pitch = 11'd16;
  localparam int               net_shift = $clog2(net_pitch);

  // goal opening, inside the posts and below the crossbar
  localparam logic [cnt_w-1:0] net_left  = post_left + post_width;
  localparam logic [cnt_w-1:0] net_right = post_right - post_width;
  localparam logic [cnt_w-1:0] net_top   = crossbar_top + post_width;

  localparam logic [cnt_w-1:0] ball_size = 11'd16;

  // 12-bit rgb colours
  localparam logic [rgb_w-1:0] black = 12'h000;
  localparam logic [rgb_w-1:0] sky   = 12'h4AF;
  localparam logic [rgb_w-1:0] grass = 12'h3A3;
  localparam logic [rgb_w-1:0] post  = 12'hCCC;
  localparam logic [rgb_w-1:0] net   = 12'hFFF;
  localparam logic [rgb_w-1:0] line  = 12'hEEE;
  localparam logic [rgb_w-1:0] ball  = 12'hF80;

  // timing of one pixel slot
  typedef struct packed {
    logic [cnt_w-1:0] hcount;
    logic [cnt_w-1:0] vcount;
    logic             hsync;
    logic             vsync;
    logic             hblnk;
    logic             vblnk;
  } timing_t;

  // timing plus the colour drawn so far
  typedef struct packed {
    timing_t          tim;
    logic [rgb_w-1:0] rgb;
  } pixel_t;

endpackage

// File: src/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
  input  logic             clk,
  input  logic             rst,
  output vga_pkg::timing_t tim
);

  logic [vga_pkg::cnt_w-1:0] hcount_nxt;
  logic [vga_pkg::cnt_w-1:0] vcount_nxt;
  logic                      line_end;
  vga_pkg::timing_t          tim_nxt;

  assign line_end = (tim.hcount == vga_pkg::hor_total - 11'd1);

  // pixel counter wraps at the end of each line
  always_comb begin
    if (line_end) begin
      hcount_nxt = '0;
    end else begin
      hcount_nxt = tim.hcount + 11'd1;
    end
  end

  // line counter steps once per line
  always_comb begin
    vcount_nxt = tim.vcount;
    if (line_end) begin
      if (tim.vcount == vga_pkg::ver_total - 11'd1) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = tim.vcount + 11'd1;
      end
    end
  end

  // flags from the next counts so they line up with the registered counts
  always_comb begin
    tim_nxt.hcount = hcount_nxt;
    tim_nxt.vcount = vcount_nxt;
    tim_nxt.hsync  = (hcount_nxt >= vga_pkg::hsync_start) &&
                     (hcount_nxt <  vga_pkg::hsync_end);
    tim_nxt.vsync  = (vcount_nxt >= vga_pkg::vsync_start) &&
                     (vcount_nxt <  vga_pkg::vsync_end);
    tim_nxt.hblnk  = (hcount_nxt >= vga_pkg::hor_pixels);
    tim_nxt.vblnk  = (vcount_nxt >= vga_pkg::ver_pixels);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tim <= '0;
    end else begin
      tim <= tim_nxt;
    end
  end

endmodule

// File: test/goal_view_assertions.sv
`timescale 1ns/1ns

module goal_view_assertions (
  input logic            clk,
  input logic            rst,
  input vga_pkg::pixel_t vga
);

  // failure counts, read by the testbench summary
  int reset_fails = 0;
  int sync_fails  = 0;
  int blank_fails = 0;

  // run lengths of the sync pulses and spacing of hsync
  int   hs_run;
  int   hs_gap;
  int   vs_run;
  logic hs_seen;
  logic hsync_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      hs_run  <= 0;
      hs_gap  <= 0;
      vs_run  <= 0;
      hs_seen <= 1'b0;
      hsync_q <= 1'b0;
    end else begin
      hsync_q <= vga.tim.hsync;
      hs_run  <= vga.tim.hsync ? hs_run + 1 : 0;
      vs_run  <= vga.tim.vsync ? vs_run + 1 : 0;
      if (vga.tim.hsync && !hsync_q) begin
        hs_gap  <= 1;
        hs_seen <= 1'b1;
      end else begin
        hs_gap <= hs_gap + 1;
      end
    end
  end

  // reset state, also on the first cycle after release
  reset_zero: assert property (@(posedge clk) rst |=> (vga == '0))
    else begin
      reset_fails++;
      $error("output not cleared during reset");
    end

  hsync_width: assert property (@(posedge clk) disable iff (rst)
    $fell(vga.tim.hsync) |-> (hs_run == int'(vga_pkg::hsync_end - vga_pkg::hsync_start)))
    else begin
      sync_fails++;
      $error("hsync pulse has the wrong width");
    end

  hsync_period: assert property (@(posedge clk) disable iff (rst)
    ($rose(vga.tim.hsync) && hs_seen) |-> (hs_gap == int'(vga_pkg::hor_total)))
    else begin
      sync_fails++;
      $error("hsync pulses are not one line apart");
    end

  vsync_width: assert property (@(posedge clk) disable iff (rst)
    $fell(vga.tim.vsync) |->
      (vs_run == int'(vga_pkg::vsync_end - vga_pkg::vsync_start) * int'(vga_pkg::hor_total)))
    else begin
      sync_fails++;
      $error("vsync pulse does not cover four lines");
    end

  // sync pulses sit inside blanking
  hsync_blank: assert property (@(posedge clk) disable iff (rst)
    vga.tim.hsync |-> vga.tim.hblnk)
    else begin
      sync_fails++;
      $error("hsync active outside horizontal blanking");
    end

  vsync_blank: assert property (@(posedge clk) disable iff (rst)
    vga.tim.vsync |-> vga.tim.vblnk)
    else begin
      sync_fails++;
      $error("vsync active outside vertical blanking");
    end

  blank_black: assert property (@(posedge clk) disable iff (rst)
    (vga.tim.hblnk || vga.tim.vblnk) |-> (vga.rgb == vga_pkg::black))
    else begin
      blank_fails++;
      $error("colour is not black during blanking");
    end

endmodule

bind goal_view_top goal_view_assertions u_assertions (
  .clk (clk),
  .rst (rst),
  .vga (vga)
);

// File: test/goal_view_tb.sv
`timescale 1ns/1ns

module goal_view_tb;

  localparam logic [31:0] seed          = 32'h545bcc7d;
  localparam int          clk_period    = 20;
  localparam int          frame_cycles  = int'(vga_pkg::hor_total) * int'(vga_pkg::ver_total);
  // reset, lead-in frame and three checked frames, with margin
  localparam int          run_cycles    = 5 * frame_cycles + 1000;
  localparam int          max_err_lines = 16;

  logic                      clk;
  logic                      rst;
  logic [vga_pkg::cnt_w-1:0] ball_x;
  logic [vga_pkg::cnt_w-1:0] ball_y;
  vga_pkg::pixel_t           vga;

  logic [31:0] lcg_state;
  int          test_errs;
  int          test_checks;
  int          tests_run;
  int          tests_failed;
  int          pos_a_x;
  int          pos_a_y;
  int          pos_b_x;
  int          pos_b_y;

  goal_view_top DUT (
    .clk    (clk),
    .rst    (rst),
    .ball_x (ball_x),
    .ball_y (ball_y),
    .vga    (vga)
  );

  always #(clk_period / 2) clk = ~clk;

  initial begin
    #(run_cycles * clk_period);
    $display("watchdog: run did not finish within %0d cycles", run_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_coord(input int limit, output int c);
    lcg_state = lcg_next(lcg_state);
    c = int'(lcg_state[31:16]) % limit;
  endtask

  function automatic bit in_square(input int h, input int v, input int x, input int y);
    return (h >= x) && (h < x + int'(vga_pkg::ball_size)) &&
           (v >= y) && (v < y + int'(vga_pkg::ball_size));
  endfunction

  // expected scene colour of a visible pixel
  function automatic logic [vga_pkg::rgb_w-1:0] background_rgb(input int h, input int v);
    int pl;
    int pr;
    int pw;
    int ct;
    int pitch;
    bit frame;
    bit opening;
    bit lines;
    pl    = int'(vga_pkg::post_left);
    pr    = int'(vga_pkg::post_right);
    pw    = int'(vga_pkg::post_width);
    ct    = int'(vga_pkg::crossbar_top);
    pitch = int'(vga_pkg::net_pitch);
    // right post counted back from its outer column
    frame = (v >= ct && v < int'(vga_pkg::goal_line_bottom) &&
             ((h >= pl && h < pl + pw) || (h > pr - pw && h <= pr))) ||
            (v >= ct && v < ct + pw && h >= pl && h <= pr);
    opening = (h >= pl + pw) && (h <= pr - pw) &&
              (v >= ct + pw) && (v < int'(vga_pkg::goal_line_top));
    lines = (v >= int'(vga_pkg::goal_line_top) && v < int'(vga_pkg::goal_line_bottom)) ||
            (v >= int'(vga_pkg::six_yard_top) && v < int'(vga_pkg::six_yard_bottom)) ||
            (h >= int'(vga_pkg::spot_x) - int'(vga_pkg::spot_half) &&
             h <  int'(vga_pkg::spot_x) + int'(vga_pkg::spot_half) &&
             v >= int'(vga_pkg::spot_y) - int'(vga_pkg::spot_half) &&
             v <  int'(vga_pkg::spot_y) + int'(vga_pkg::spot_half));
    if (frame) begin
      return vga_pkg::post;
    end
    if (opening && (((h - pl) % pitch == 0) || ((v - ct) % pitch == 0))) begin
      return vga_pkg::net;
    end
    if (lines) begin
      return vga_pkg::line;
    end
    if (v >= int'(vga_pkg::grass_top)) begin
      return vga_pkg::grass;
    end
    return vga_pkg::sky;
  endfunction

  task automatic check_rgb(input string name, input int h, input int v,
                           input logic [vga_pkg::rgb_w-1:0] exp);
    test_checks++;
    assert (vga.rgb == exp) else begin
      test_errs++;
      if (test_errs <= max_err_lines) begin
        $display("ERR %s pixel (%0d,%0d): expected %h, actual %h", name, h, v, exp, vga.rgb);
      end
    end
  endtask

  // called on a falling edge, returns on one
  task automatic wait_pixel(input int h, input int v);
    while (int'(vga.tim.hcount) != h || int'(vga.tim.vcount) != v) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errs, input int checks);
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok, %0d pixel checks", name, checks);
    end else begin
      tests_failed++;
      $display("test %s: %0d failures, %0d pixel checks", name, errs, checks);
    end
  endtask

  // one whole output frame, ball square skipped unless with_ball
  task automatic check_frame(input string name, input int bx, input int by, input bit with_ball);
    int h;
    int v;
    test_errs   = 0;
    test_checks = 0;
    wait_pixel(0, 0);
    repeat (frame_cycles) begin
      h = int'(vga.tim.hcount);
      v = int'(vga.tim.vcount);
      if (h < int'(vga_pkg::hor_pixels) && v < int'(vga_pkg::ver_pixels)) begin
        if (!in_square(h, v, bx, by)) begin
          check_rgb(name, h, v, background_rgb(h, v));
        end else if (with_ball) begin
          check_rgb(name, h, v, vga_pkg::ball);
        end
      end
      @(negedge clk);
    end
    report_test(name, test_errs, test_checks);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    ball_x       = '0;
    ball_y       = '0;
    lcg_state    = seed;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    report_test("reset", DUT.u_assertions.reset_fails, 0);

    // first position, latched at the end of the lead-in frame
    random_coord(int'(vga_pkg::hor_pixels - vga_pkg::ball_size), pos_a_x);
    random_coord(int'(vga_pkg::ver_pixels - vga_pkg::ball_size), pos_a_y);
    ball_x = pos_a_x[vga_pkg::cnt_w-1:0];
    ball_y = pos_a_y[vga_pkg::cnt_w-1:0];
    wait_pixel(0, int'(vga_pkg::ver_pixels));
    check_frame("scene", pos_a_x, pos_a_y, 1'b0);

    random_coord(int'(vga_pkg::hor_pixels - vga_pkg::ball_size), pos_b_x);
    random_coord(int'(vga_pkg::ver_pixels - vga_pkg::ball_size), pos_b_y);
    // move the ball halfway down a frame, old position must hold
    fork
      check_frame("ball_hold", pos_a_x, pos_a_y, 1'b1);
      begin
        wait_pixel(0, int'(vga_pkg::ver_pixels) / 2);
        ball_x = pos_b_x[vga_pkg::cnt_w-1:0];
        ball_y = pos_b_y[vga_pkg::cnt_w-1:0];
      end
    join
    check_frame("ball_move", pos_b_x, pos_b_y, 1'b1);

    report_test("sync", DUT.u_assertions.sync_fails, 0);
    report_test("blanking", DUT.u_assertions.blank_fails, 0);
    $display("summary: %0d tests, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
